// File: decodePkg.sv
// Decode stage package
// Instruction formats, opcode and function codes, control bundle
// and the ID/EX record shared by the decode stage blocks

`default_nettype none

package decodePkg;

    //--------------------------------------------------
    // Widths
    //--------------------------------------------------
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount     = 32;
    localparam int linkReg      = 31;     // Return address register for jal

    //--------------------------------------------------
    // Opcodes and function codes
    //--------------------------------------------------
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opAndi  = 6'h0C;
    localparam logic [5:0] opOri   = 6'h0D;
    localparam logic [5:0] opLui   = 6'h0F;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2B;

    localparam logic [5:0] fnJr    = 6'h08;
    localparam logic [5:0] fnMult  = 6'h18;
    localparam logic [5:0] fnAdd   = 6'h20;   // ALU codes for immediate forms
    localparam logic [5:0] fnAddu  = 6'h21;
    localparam logic [5:0] fnSub   = 6'h22;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;

    // Operand selects
    typedef enum logic [1:0] {
        immSign,
        immZero,
        immUpper,
        immJump
    } immSelT;

    typedef enum logic [1:0] {
        dstRt,
        dstRd,
        dstLink
    } dstSelT;

    //--------------------------------------------------
    // Instruction word, one view per format
    //--------------------------------------------------
    typedef struct packed {
        logic [5:0]              opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } rFmtT;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [15:0]             imm16;
    } iFmtT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } jFmtT;

    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
        jFmtT jFmt;
    } instrT;

    // Execute, memory and writeback controls
    typedef struct packed {
        logic       branch;
        logic       jump;
        logic       jumpReg;
        logic       memRead;
        logic       memToReg;
        logic       memWrite;
        logic       aluSrc;       // Second ALU operand is immData
        logic       aluOp;        // ALU op taken from the R-type funct
        logic       mulOp;
        logic       regWrite;
        logic [5:0] aluFunc;
    } ctrlT;

    typedef struct packed {
        ctrlT                    ctrl;
        logic [dataWidth-1:0]    pcInc;
        logic [dataWidth-1:0]    rsData;
        logic [dataWidth-1:0]    rtData;
        logic [dataWidth-1:0]    immData;
        logic [regAddrWidth-1:0] dstAddr;
        logic [4:0]              shamt;
    } idExT;

endpackage

`default_nettype wire

// File: controlDecoder.sv
// Control decoder
// Maps opcode and function fields to the execute, memory and
// writeback controls plus the immediate and destination selects

`timescale 1ns/1ns
`default_nettype none

module controlDecoder (
    input  wire [5:0]         opcode,
    input  wire [5:0]         funct,
    output decodePkg::ctrlT   ctrl,
    output decodePkg::immSelT immSel,
    output decodePkg::dstSelT dstSel
);
    import decodePkg::*;

    always_comb begin
        ctrl   = '0;              // Unknown opcodes fall out as a no-op
        immSel = immSign;
        dstSel = dstRt;

        case (opcode)
            opRType: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = 1'b1;
                ctrl.aluFunc  = funct;
                dstSel        = dstRd;
                case (funct)
                    fnMult: ctrl.mulOp = 1'b1;
                    fnJr: begin
                        ctrl.jumpReg  = 1'b1;
                        ctrl.regWrite = 1'b0;   // jr writes nothing
                    end
                    default: ;
                endcase
            end

            //--------------------------------------------------
            // Immediate arithmetic and logic
            //--------------------------------------------------
            opAddi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluFunc  = fnAdd;
            end
            opAddiu: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluFunc  = fnAddu;
            end
            opAndi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluFunc  = fnAnd;
                immSel        = immZero;
            end
            opOri: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluFunc  = fnOr;
                immSel        = immZero;
            end
            opLui: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluFunc  = fnOr;     // rs is r0, result is the upper immediate
                immSel        = immUpper;
            end

            // Memory access
            opLw: begin
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluFunc  = fnAdd;    // Base plus offset
            end
            opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluFunc  = fnAdd;
            end

            // Control flow
            opBeq: begin
                ctrl.branch  = 1'b1;
                ctrl.aluFunc = fnSub;     // Compare rs and rt
            end
            opJ: begin
                ctrl.jump = 1'b1;
                immSel    = immJump;
            end
            opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                immSel        = immJump;
                dstSel        = dstLink;
            end

            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: registerFile.sv
// Register file
// 32 by 32 architectural registers, written by the writeback stage,
// two combinational read ports with write-through bypass, r0 reads zero

`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input  wire                                Clock,
    input  wire                                reset,
    input  wire                                writeEnable,
    input  wire [decodePkg::regAddrWidth-1:0]  writeAddr,
    input  wire [decodePkg::dataWidth-1:0]     writeData,
    input  wire [decodePkg::regAddrWidth-1:0]  rsAddr,
    input  wire [decodePkg::regAddrWidth-1:0]  rtAddr,
    output logic [decodePkg::dataWidth-1:0]    rsData,
    output logic [decodePkg::dataWidth-1:0]    rtData
);
    import decodePkg::*;

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;       // r0 is never written
        end
    end

    // Shared read path for both ports
    function automatic logic [dataWidth-1:0] readPort(
        input logic [regAddrWidth-1:0] addr
    );
        if (addr == '0)
            return '0;
        else if (writeEnable && writeAddr == addr)
            return writeData;                   // Same-cycle bypass
        else
            return regs[addr];
    endfunction

    always_comb begin
        rsData = readPort(rsAddr);
        rtData = readPort(rtAddr);
    end

    // A stored word reads back on the next cycle unless overwritten again
    property writeReadsBack;
        @(posedge Clock) disable iff (reset)
            (writeEnable && writeAddr != '0) |=>
                (rsAddr != $past(writeAddr) ||
                 (writeEnable && writeAddr == rsAddr) ||
                 rsData == $past(writeData));
    endproperty

    assert property (writeReadsBack)
        else $error("registerFile: written value not read back");

endmodule

`default_nettype wire

// File: operandGen.sv
// Operand generator
// Builds the immediate operand in one of four forms and picks the
// destination register for writeback

`timescale 1ns/1ns
`default_nettype none

module operandGen (
    input  wire decodePkg::instrT               instr,
    input  wire decodePkg::immSelT              immSel,
    input  wire decodePkg::dstSelT              dstSel,
    output logic [decodePkg::dataWidth-1:0]     immData,
    output logic [decodePkg::regAddrWidth-1:0]  dstAddr
);
    import decodePkg::*;

    logic [15:0] imm16;

    assign imm16 = instr.iFmt.imm16;

    //--------------------------------------------------
    // Immediate forms
    //--------------------------------------------------
    always_comb begin
        case (immSel)
            immSign:  immData = {{16{imm16[15]}}, imm16};
            immZero:  immData = {16'h0000, imm16};         // andi, ori
            immUpper: immData = {imm16, 16'h0000};         // lui
            immJump:  immData = {6'd0, instr.jFmt.target26};
            default:  immData = '0;
        endcase
    end

    // Destination register
    always_comb begin
        case (dstSel)
            dstRd:   dstAddr = instr.rFmt.rd;
            dstLink: dstAddr = regAddrWidth'(linkReg);    // jal return address
            default: dstAddr = instr.iFmt.rt;
        endcase
    end

endmodule

`default_nettype wire

// File: idExRegister.sv
// ID/EX pipeline register
// Loads the decoded instruction, holds on stall and drops it on flush,
// controls forced to zero whenever the entry is not valid

`timescale 1ns/1ns
`default_nettype none

module idExRegister (
    input  wire                  Clock,
    input  wire                  reset,
    input  wire                  stall,
    input  wire                  flush,
    input  wire                  inValid,
    input  wire decodePkg::idExT decoded,
    output logic                 outValid,
    output decodePkg::idExT      idEx
);
    import decodePkg::*;

    ctrlT ctrlQ;
    idExT dataQ;

    // Valid and control bits, flush wins over stall
    always_ff @(posedge Clock) begin
        if (reset) begin
            outValid <= 1'b0;
            ctrlQ    <= '0;
        end else if (flush) begin
            outValid <= 1'b0;
            ctrlQ    <= '0;
        end else if (!stall) begin
            outValid <= inValid;
            ctrlQ    <= inValid ? decoded.ctrl : '0;   // Bubble carries no writes
        end
    end

    // Operand payload
    always_ff @(posedge Clock) begin
        if (!stall) begin
            dataQ <= decoded;
        end
    end

    always_comb begin
        idEx      = dataQ;
        idEx.ctrl = ctrlQ;
    end

    //--------------------------------------------------
    // Checks
    //--------------------------------------------------
    assert property (@(posedge Clock) disable iff (reset) flush |=> !outValid)
        else $error("idExRegister: outValid high after flush");

    assert property (@(posedge Clock) disable iff (reset)
        (stall && !flush) |=> ($stable(outValid) && $stable(idEx)))
        else $error("idExRegister: entry changed during stall");

endmodule

`default_nettype wire

// File: decodeStage.sv
// Instruction decode stage
// Decodes one fetched instruction, reads its source registers and
// forms the operands, then registers the result into ID/EX

`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input  wire                                Clock,
    input  wire                                reset,
    input  wire                                inValid,
    input  wire decodePkg::instrT              instruction,
    input  wire [decodePkg::dataWidth-1:0]     pcInc,
    input  wire                                stall,
    input  wire                                flush,
    input  wire                                wbEnable,
    input  wire [decodePkg::regAddrWidth-1:0]  wbAddr,
    input  wire [decodePkg::dataWidth-1:0]     wbData,
    output logic                               outValid,
    output decodePkg::idExT                    idEx
);
    import decodePkg::*;

    ctrlT                    ctrl;
    immSelT                  immSel;
    dstSelT                  dstSel;
    logic [dataWidth-1:0]    rsData;
    logic [dataWidth-1:0]    rtData;
    logic [dataWidth-1:0]    immData;
    logic [regAddrWidth-1:0] dstAddr;
    idExT                    decoded;

    //--------------------------------------------------
    // Combinational decode
    //--------------------------------------------------
    controlDecoder u_controlDecoder (
        .opcode (instruction.rFmt.opcode),
        .funct  (instruction.rFmt.funct),
        .ctrl   (ctrl),
        .immSel (immSel),
        .dstSel (dstSel)
    );

    registerFile u_registerFile (
        .Clock       (Clock),
        .reset       (reset),
        .writeEnable (wbEnable),
        .writeAddr   (wbAddr),
        .writeData   (wbData),
        .rsAddr      (instruction.rFmt.rs),
        .rtAddr      (instruction.rFmt.rt),
        .rsData      (rsData),
        .rtData      (rtData)
    );

    operandGen u_operandGen (
        .instr   (instruction),
        .immSel  (immSel),
        .dstSel  (dstSel),
        .immData (immData),
        .dstAddr (dstAddr)
    );

    // Assemble the ID/EX record
    always_comb begin
        decoded.ctrl    = ctrl;
        decoded.pcInc   = pcInc;          // Passed on for branches and jal
        decoded.rsData  = rsData;
        decoded.rtData  = rtData;
        decoded.immData = immData;
        decoded.dstAddr = dstAddr;
        decoded.shamt   = instruction.rFmt.shamt;
    end

    idExRegister u_idExRegister (
        .Clock    (Clock),
        .reset    (reset),
        .stall    (stall),
        .flush    (flush),
        .inValid  (inValid),
        .decoded  (decoded),
        .outValid (outValid),
        .idEx     (idEx)
    );

endmodule

`default_nettype wire

// File: tbDecodeStage.sv
// Decode stage testbench
// Random instructions, writeback traffic, stall and flush, checked
// against a model of the decode table, register file and ID/EX slot

`timescale 1ns/1ns
`default_nettype none

module tbDecodeStage;
    import decodePkg::*;

    localparam int resetCycles = 10;
    localparam int testCycles  = 2000;
    localparam int maxCycles   = 3000;    // Reset and test cycles plus margin

    logic                    Clock;
    logic                    reset;
    logic                    inValid;
    instrT                   instruction;
    logic [dataWidth-1:0]    pcInc;
    logic                    stall;
    logic                    flush;
    logic                    wbEnable;
    logic [regAddrWidth-1:0] wbAddr;
    logic [dataWidth-1:0]    wbData;
    logic                    outValid;
    idExT                    idEx;

    logic [dataWidth-1:0] modelRegs [regCount];
    logic                 expValid;
    idExT                 expEntry;
    idExT                 nextEntry;
    int                   cycleCount;
    int                   checkCount;
    int                   errorCount;

    logic [5:0] legalOps [11] = '{opRType, opAddi, opAddiu, opAndi, opOri, opLui,
                                  opLw, opSw, opBeq, opJ, opJal};
    logic [5:0] illegalOps [6] = '{6'h01, 6'h05, 6'h10, 6'h1A, 6'h2F, 6'h3F};

    decodeStage u_decodeStage (
        .Clock       (Clock),
        .reset       (reset),
        .inValid     (inValid),
        .instruction (instruction),
        .pcInc       (pcInc),
        .stall       (stall),
        .flush       (flush),
        .wbEnable    (wbEnable),
        .wbAddr      (wbAddr),
        .wbData      (wbData),
        .outValid    (outValid),
        .idEx        (idEx)
    );

    always #50 Clock = ~Clock;

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount >= maxCycles) begin
            $display("Timeout: run stopped after %0d cycles", cycleCount);
            $display("Test FAILED");
            $finish;
        end
    end

    //--------------------------------------------------
    // Reference model
    //--------------------------------------------------
    function automatic ctrlT expectedCtrl(input logic [5:0] op, input logic [5:0] fn);
        ctrlT c;
        logic rType;
        rType      = (op == opRType);
        c          = '0;
        c.branch   = (op == opBeq);
        c.jump     = (op == opJ) || (op == opJal);
        c.jumpReg  = rType && fn == fnJr;
        c.memRead  = (op == opLw);
        c.memToReg = (op == opLw);
        c.memWrite = (op == opSw);
        c.aluSrc   = op inside {opAddi, opAddiu, opAndi, opOri, opLui, opLw, opSw};
        c.aluOp    = rType;
        c.mulOp    = rType && fn == fnMult;
        c.regWrite = (rType && fn != fnJr) ||
                     op inside {opAddi, opAddiu, opAndi, opOri, opLui, opLw, opJal};
        case (op)
            opRType:            c.aluFunc = fn;
            opAddi, opLw, opSw: c.aluFunc = fnAdd;     // Address and add forms
            opAddiu:            c.aluFunc = fnAddu;
            opAndi:             c.aluFunc = fnAnd;
            opOri, opLui:       c.aluFunc = fnOr;
            opBeq:              c.aluFunc = fnSub;
            default:            c.aluFunc = '0;
        endcase
        return c;
    endfunction

    // Register read as seen before the edge, bypass included
    function automatic logic [dataWidth-1:0] modelRead(input logic [regAddrWidth-1:0] addr);
        if (addr == '0)
            return '0;
        if (wbEnable && wbAddr == addr)
            return wbData;
        return modelRegs[addr];
    endfunction

    function automatic idExT expectedEntry(input instrT ins, input logic [dataWidth-1:0] pc);
        idExT        e;
        logic [15:0] imm;
        imm       = ins.iFmt.imm16;
        e.ctrl    = expectedCtrl(ins.rFmt.opcode, ins.rFmt.funct);
        e.pcInc   = pc;
        e.rsData  = modelRead(ins.rFmt.rs);
        e.rtData  = modelRead(ins.rFmt.rt);
        e.shamt   = ins.rFmt.shamt;
        e.dstAddr = ins.iFmt.rt;
        e.immData = {{16{imm[15]}}, imm};
        case (ins.rFmt.opcode)
            opRType:      e.dstAddr = ins.rFmt.rd;
            opAndi, opOri: e.immData = {16'h0000, imm};
            opLui:        e.immData = {imm, 16'h0000};
            opJ:          e.immData = {6'd0, ins.jFmt.target26};
            opJal: begin
                e.immData = {6'd0, ins.jFmt.target26};
                e.dstAddr = regAddrWidth'(linkReg);
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic checkValue(input string field, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("FAIL %0t: %s is %h, expected %h", $time, field, got, exp);
        end
    endtask

    // One clock edge, then model update and compare
    task automatic stepAndCheck;
        nextEntry = expectedEntry(instruction, pcInc);
        @(posedge Clock);
        if (wbEnable && wbAddr != '0)
            modelRegs[wbAddr] = wbData;
        if (flush) begin
            expValid = 1'b0;                 // Flush wins over stall
        end else if (!stall) begin
            expValid = inValid;
            expEntry = nextEntry;
        end
        #1;
        checkValue("outValid", outValid, expValid);
        checkValue("ctrl", idEx.ctrl, expValid ? expEntry.ctrl : '0);
        if (expValid) begin
            checkValue("pcInc", idEx.pcInc, expEntry.pcInc);
            checkValue("rsData", idEx.rsData, expEntry.rsData);
            checkValue("rtData", idEx.rtData, expEntry.rtData);
            checkValue("immData", idEx.immData, expEntry.immData);
            checkValue("dstAddr", idEx.dstAddr, expEntry.dstAddr);
            checkValue("shamt", idEx.shamt, expEntry.shamt);
        end
    endtask

    //--------------------------------------------------
    // Stimulus
    //--------------------------------------------------
    task automatic driveRandom(input logic holdFetch);
        if (!holdFetch) begin                // Fetch keeps its word while stalled
            instruction = $urandom;
            if ($urandom % 8 < 6)
                instruction.rFmt.opcode = legalOps[$urandom % 11];
            else
                instruction.rFmt.opcode = illegalOps[$urandom % 6];
            if (instruction.rFmt.opcode == opRType && $urandom % 3 == 0)
                instruction.rFmt.funct = ($urandom % 2) ? fnMult : fnJr;
            pcInc   = $urandom & ~32'h3;
            inValid = ($urandom % 10) != 0;
        end
        wbEnable = ($urandom % 4) == 0;
        case ($urandom % 4)
            0:       wbAddr = '0;
            1:       wbAddr = instruction.rFmt.rs;   // Exercise the bypass
            2:       wbAddr = instruction.rFmt.rt;
            default: wbAddr = regAddrWidth'($urandom);
        endcase
        wbData = $urandom;
        stall  = ($urandom % 10) == 0;
        flush  = ($urandom % 10) == 0;
    endtask

    initial begin
        void'($urandom(13029));
        Clock       = 1'b0;
        reset       = 1'b1;
        inValid     = 1'b1;               // Valid R-type word must not pass reset
        instruction = '0;
        pcInc       = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        wbEnable    = 1'b0;
        wbAddr      = '0;
        wbData      = '0;
        expValid    = 1'b0;
        expEntry    = '0;
        cycleCount  = 0;
        checkCount  = 0;
        errorCount  = 0;
        for (int i = 0; i < regCount; i++)
            modelRegs[i] = '0;

        repeat (resetCycles) @(posedge Clock);
        #1;
        checkValue("outValid after reset", outValid, 1'b0);
        checkValue("ctrl after reset", idEx.ctrl, '0);
        #9;
        reset = 1'b0;

        // Cleared register file reads zero
        instruction             = $urandom;
        instruction.rFmt.opcode = opRType;
        inValid                 = 1'b1;
        stepAndCheck();
        checkValue("rsData after reset", idEx.rsData, '0);
        checkValue("rtData after reset", idEx.rtData, '0);

        for (int n = 0; n < testCycles; n++) begin
            #9;
            driveRandom(stall);
            stepAndCheck();
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: Bender.yml
package:
  name: decodeStage

sources:
  - files:
      - decodePkg.sv
      - controlDecoder.sv
      - registerFile.sv
      - operandGen.sv
      - idExRegister.sv
      - decodeStage.sv
  - target: test
    files:
      - tbDecodeStage.sv

// File: tb.f
decodePkg.sv
controlDecoder.sv
registerFile.sv
operandGen.sv
idExRegister.sv
decodeStage.sv
tbDecodeStage.sv
